/* bus_addr_decoder.sv */
// ==========================================================================
// Bus address decoder
// Routes core accesses to data SRAM, instruction SRAM or UART registers,
// returns read data one cycle later and keeps the free-running cycle counter
// ==========================================================================
`timescale 1ns/1ps

module bus_addr_decoder (
    input  logic                                clk_g,
    input  logic                                rst_g,
    input  soc_bus_pkg::core_req_t              req,
    output logic                                ready,
    output soc_bus_pkg::core_rsp_t              rsp,
    output soc_bus_pkg::dmem_req_t              dmem,
    input  logic [soc_bus_pkg::DATA_BITS-1:0]   dmem_dout,
    output soc_bus_pkg::imem_wr_t               imem,
    output logic                                tx_push,
    output uart_pkg::uart_byte_t                tx_byte,
    input  logic                                tx_full,
    input  logic                                rx_valid,
    input  uart_pkg::uart_byte_t                rx_byte,
    input  logic                                rx_overrun,
    output logic                                rx_consume
);

    soc_bus_pkg::bus_region_e                   region;
    soc_bus_pkg::bus_region_e                   region_q;
    logic                                       is_read;
    logic                                       is_write;
    logic                                       accept;
    logic [3:0]                                 uart_off;
    logic [soc_bus_pkg::DATA_BITS-1:0]          uart_rdata;
    logic [soc_bus_pkg::DATA_BITS-1:0]          rdata_q;
    logic [soc_bus_pkg::DATA_BITS-1:0]          cycles;
    logic                                       rsp_valid_q;

    // ======================================================================
    // Region decode and handshake
    // ======================================================================

    always_comb begin
        if ((req.addr - soc_bus_pkg::DMEM_BASE) < soc_bus_pkg::DMEM_SPAN) begin
            region = soc_bus_pkg::REGION_DMEM;
        end else if ((req.addr - soc_bus_pkg::IMEM_BASE) < soc_bus_pkg::IMEM_SPAN) begin
            region = soc_bus_pkg::REGION_IMEM;
        end else if ((req.addr - soc_bus_pkg::UART_BASE) < soc_bus_pkg::UART_SPAN) begin
            region = soc_bus_pkg::REGION_UART;
        end else begin
            region = soc_bus_pkg::REGION_NONE;
        end
    end

    assign is_read  = req.rd;
    assign is_write = |req.wstrb;
    assign uart_off = req.addr[3:0];

    // Only a TX write into a full FIFO stalls
    assign ready  = !(is_write && region == soc_bus_pkg::REGION_UART &&
                      uart_off == uart_pkg::REG_TX_DATA && tx_full);
    assign accept = (is_read || is_write) && ready;

    // SRAM ports take word addresses
    assign dmem.csb   = !(accept && region == soc_bus_pkg::REGION_DMEM);
    assign dmem.web   = !(accept && is_write && region == soc_bus_pkg::REGION_DMEM);
    assign dmem.wmask = req.wstrb;
    assign dmem.addr  = req.addr[soc_bus_pkg::DMEM_ADDR_BITS+1:2];
    assign dmem.din   = req.wdata;

    assign imem.en    = accept && is_write && region == soc_bus_pkg::REGION_IMEM;
    assign imem.wmask = req.wstrb;
    assign imem.addr  = req.addr[soc_bus_pkg::IMEM_ADDR_BITS+1:2];
    assign imem.din   = req.wdata;

    // UART strobes
    assign tx_push    = accept && is_write && region == soc_bus_pkg::REGION_UART &&
                        uart_off == uart_pkg::REG_TX_DATA;
    assign tx_byte    = req.wdata[7:0];
    assign rx_consume = accept && is_read && region == soc_bus_pkg::REGION_UART &&
                        uart_off == uart_pkg::REG_RX_DATA;

    // ======================================================================
    // Read data path
    // ======================================================================

    always_comb begin
        case (uart_off)
            uart_pkg::REG_RX_DATA: uart_rdata = soc_bus_pkg::DATA_BITS'(rx_byte);
            uart_pkg::REG_STATUS:  uart_rdata = soc_bus_pkg::DATA_BITS'(
                                       {rx_overrun, rx_valid, tx_full});
            uart_pkg::REG_CYCLES:  uart_rdata = cycles;
            default:               uart_rdata = '0;
        endcase
    end

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            rsp_valid_q <= 1'b0;
            region_q    <= soc_bus_pkg::REGION_NONE;
            cycles      <= '0;
        end else begin
            rsp_valid_q <= accept && is_read;
            region_q    <= region;
            cycles      <= cycles + 1'b1;
        end
    end

    // Unmapped and instruction-region reads return zero
    always_ff @(posedge clk_g) begin
        rdata_q <= (region == soc_bus_pkg::REGION_UART) ? uart_rdata : '0;
    end

    assign rsp.valid = rsp_valid_q;
    assign rsp.rdata = (region_q == soc_bus_pkg::REGION_DMEM) ? dmem_dout : rdata_q;

endmodule

/* filelist.f */
soc_bus_pkg.sv
uart_pkg.sv
bus_addr_decoder.sv
uart_tx_fifo.sv
uart_transmitter.sv
uart_receiver.sv
soc_bus_top.sv
tb_soc_bus_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the SoC bus testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --top-module tb_soc_bus_top -f filelist.f
./obj_dir/Vtb_soc_bus_top | tee sim.log

# The testbench prints the fail message on any failed check or timeout
if grep -q "Errors found" sim.log; then
    echo "Simulation failed, see sim.log"
    exit 1
fi

echo "Simulation passed"
exit 0

/* soc_bus_pkg.sv */
// ==========================================================================
// SoC bus definitions
// Bus widths, address map, decoded regions and the structs for the core
// load/store port and the two external SRAM ports
// ==========================================================================

package soc_bus_pkg;

    localparam int ADDR_BITS      = 32;
    localparam int DATA_BITS      = 32;
    localparam int STRB_BITS      = 4;
    localparam int DMEM_ADDR_BITS = 13;
    localparam int IMEM_ADDR_BITS = 11;

    // Address map, spans in bytes
    localparam logic [ADDR_BITS-1:0] DMEM_BASE = 32'h0000_0000;
    localparam logic [ADDR_BITS-1:0] IMEM_BASE = 32'h1000_0000;
    localparam logic [ADDR_BITS-1:0] UART_BASE = 32'h2000_0000;
    localparam logic [ADDR_BITS-1:0] DMEM_SPAN = 32'(2 ** (DMEM_ADDR_BITS + 2));
    localparam logic [ADDR_BITS-1:0] IMEM_SPAN = 32'(2 ** (IMEM_ADDR_BITS + 2));
    localparam logic [ADDR_BITS-1:0] UART_SPAN = 32'd16;

    typedef enum logic [1:0] {
        REGION_DMEM,
        REGION_IMEM,
        REGION_UART,
        REGION_NONE
    } bus_region_e;

    // Core side, nonzero wstrb means a write
    typedef struct packed {
        logic [ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0] wdata;
        logic [STRB_BITS-1:0] wstrb;
        logic                 rd;
    } core_req_t;

    typedef struct packed {
        logic                 valid;
        logic [DATA_BITS-1:0] rdata;
    } core_rsp_t;

    // Data SRAM port, selects active low
    typedef struct packed {
        logic                      csb;
        logic                      web;
        logic [STRB_BITS-1:0]      wmask;
        logic [DMEM_ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]      din;
    } dmem_req_t;

    typedef struct packed {
        logic                      en;
        logic [STRB_BITS-1:0]      wmask;
        logic [IMEM_ADDR_BITS-1:0] addr;
        logic [DATA_BITS-1:0]      din;
    } imem_wr_t;

endpackage

/* soc_bus_top.sv */
// ==========================================================================
// SoC bus top level
// Address decoder with data/instruction SRAM ports and the UART behind it
// ==========================================================================
`timescale 1ns/1ps

module soc_bus_top #(
    parameter int CLKS_PER_BIT = 868,
    parameter int FIFO_DEPTH   = 8
) (
    input  logic                              clk_g,
    input  logic                              rst_g,
    input  soc_bus_pkg::core_req_t            req,
    output logic                              ready,
    output soc_bus_pkg::core_rsp_t            rsp,
    output soc_bus_pkg::dmem_req_t            dmem,
    input  logic [soc_bus_pkg::DATA_BITS-1:0] dmem_dout,
    output soc_bus_pkg::imem_wr_t             imem,
    input  logic                              rx,
    output logic                              tx
);

    // Decoder to UART strobes
    logic                 tx_push;
    uart_pkg::uart_byte_t tx_byte;
    logic                 tx_full;
    logic                 rx_consume;

    // FIFO to transmitter
    logic                 tx_valid;
    uart_pkg::uart_byte_t tx_head;
    logic                 tx_pop;

    // Receiver levels
    logic                 rx_valid;
    uart_pkg::uart_byte_t rx_byte;
    logic                 rx_overrun;

    bus_addr_decoder bus_addr_decoder_inst (
        .clk_g      (clk_g),
        .rst_g      (rst_g),
        .req        (req),
        .ready      (ready),
        .rsp        (rsp),
        .dmem       (dmem),
        .dmem_dout  (dmem_dout),
        .imem       (imem),
        .tx_push    (tx_push),
        .tx_byte    (tx_byte),
        .tx_full    (tx_full),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .rx_overrun (rx_overrun),
        .rx_consume (rx_consume)
    );

    uart_tx_fifo #(
        .FIFO_DEPTH (FIFO_DEPTH)
    ) uart_tx_fifo_inst (
        .clk_g    (clk_g),
        .rst_g    (rst_g),
        .tx_push  (tx_push),
        .tx_byte  (tx_byte),
        .tx_pop   (tx_pop),
        .tx_full  (tx_full),
        .tx_valid (tx_valid),
        .tx_head  (tx_head)
    );

    uart_transmitter #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_transmitter_inst (
        .clk_g    (clk_g),
        .rst_g    (rst_g),
        .tx_valid (tx_valid),
        .tx_head  (tx_head),
        .tx_pop   (tx_pop),
        .tx       (tx)
    );

    uart_receiver #(
        .CLKS_PER_BIT (CLKS_PER_BIT)
    ) uart_receiver_inst (
        .clk_g      (clk_g),
        .rst_g      (rst_g),
        .rx         (rx),
        .rx_consume (rx_consume),
        .rx_valid   (rx_valid),
        .rx_byte    (rx_byte),
        .rx_overrun (rx_overrun)
    );

endmodule

/* tb_soc_bus_top.sv */
// ==========================================================================
// SoC bus testbench
// Directed tests of the address decoder and UART with SRAM models and a
// UART line model on tx and rx
// ==========================================================================
`timescale 1ns/1ps

module tb_soc_bus_top;

    localparam int CPB            = 8;
    localparam int DEPTH          = 4;
    // Five and six tx frames, three rx frames
    localparam int FRAME_COUNT    = 14;
    localparam int TIMEOUT_CYCLES = 2 * FRAME_COUNT * 10 * CPB + 500;
    localparam logic [31:0] TX_ADDR     = soc_bus_pkg::UART_BASE + 32'(uart_pkg::REG_TX_DATA);
    localparam logic [31:0] RX_ADDR     = soc_bus_pkg::UART_BASE + 32'(uart_pkg::REG_RX_DATA);
    localparam logic [31:0] STATUS_ADDR = soc_bus_pkg::UART_BASE + 32'(uart_pkg::REG_STATUS);
    localparam logic [31:0] CYCLES_ADDR = soc_bus_pkg::UART_BASE + 32'(uart_pkg::REG_CYCLES);

    logic                   clk_g;
    logic                   rst_g;
    logic                   ready;
    logic                   rx;
    logic                   tx;
    logic [31:0]            dmem_dout;
    soc_bus_pkg::core_req_t req;
    soc_bus_pkg::core_rsp_t rsp;
    soc_bus_pkg::dmem_req_t dmem;
    soc_bus_pkg::imem_wr_t  imem;

    logic [31:0]            dmem_mem [2**soc_bus_pkg::DMEM_ADDR_BITS];
    logic [31:0]            imem_mem [2**soc_bus_pkg::IMEM_ADDR_BITS];
    uart_pkg::uart_byte_t   tx_seen [$];
    logic [31:0]            lfsr;
    int                     cycle_cnt = 0;
    int                     errors = 0;
    int                     checks = 0;

    soc_bus_top #(
        .CLKS_PER_BIT (CPB),
        .FIFO_DEPTH   (DEPTH)
    ) soc_bus_top_inst (
        .clk_g     (clk_g),
        .rst_g     (rst_g),
        .req       (req),
        .ready     (ready),
        .rsp       (rsp),
        .dmem      (dmem),
        .dmem_dout (dmem_dout),
        .imem      (imem),
        .rx        (rx),
        .tx        (tx)
    );

    initial begin
        clk_g = 1'b0;
        forever #4 clk_g = ~clk_g;
    end

    always @(posedge clk_g) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Errors found");
            $finish;
        end
    end

    // ======================================================================
    // Memory and line models
    // ======================================================================

    // Data SRAM, one-cycle read latency
    always @(posedge clk_g) begin
        if (!dmem.csb) begin
            if (!dmem.web) begin
                for (int b = 0; b < 4; b++) begin
                    if (dmem.wmask[b]) dmem_mem[dmem.addr][8*b +: 8] <= dmem.din[8*b +: 8];
                end
            end else begin
                dmem_dout <= dmem_mem[dmem.addr];
            end
        end
    end

    always @(posedge clk_g) begin
        if (imem.en) begin
            for (int b = 0; b < 4; b++) begin
                if (imem.wmask[b]) imem_mem[imem.addr][8*b +: 8] <= imem.din[8*b +: 8];
            end
        end
    end

    // Decodes tx frames, sampling each bit at its middle
    initial begin : tx_line_model
        uart_pkg::uart_byte_t b;
        forever begin
            @(negedge clk_g);
            if (tx === 1'b0) begin
                repeat (CPB + CPB / 2) @(negedge clk_g);
                for (int i = 0; i < 8; i++) begin
                    b[i] = tx;
                    repeat (CPB) @(negedge clk_g);
                end
                assert (tx === 1'b1) else begin
                    errors++;
                    $display("A tx frame ended with a low stop bit at %0t", $time);
                end
                tx_seen.push_back(b);
            end
        end
    end

    // ======================================================================
    // Helpers
    // ======================================================================

    function automatic logic [31:0] fill_word(input int waddr);
        return (32'(waddr) * 32'h9e37_79b9) ^ 32'h5a5a_0f0f;
    endfunction

    // Galois LFSR, one step per bit taken
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            v = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old_w,
                                                input logic [31:0] wdata,
                                                input logic [3:0]  strb);
        logic [31:0] r;
        r = old_w;
        for (int b = 0; b < 4; b++) begin
            if (strb[b]) r[8*b +: 8] = wdata[8*b +: 8];
        end
        return r;
    endfunction

    task automatic check_eq(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        assert (got === exp) else begin
            errors++;
            $display("[ERROR] %0t %s: expected %h, got %h", $time, name, exp, got);
        end
    endtask

    // Drives a request at a falling edge and holds it until ready
    task automatic start_access(input logic [31:0] addr, input logic [31:0] wdata,
                                input logic [3:0] wstrb, input logic rd, output int stalls);
        stalls    = 0;
        req.addr  = addr;
        req.wdata = wdata;
        req.wstrb = wstrb;
        req.rd    = rd;
        #1;
        while (!ready) begin
            stalls++;
            @(negedge clk_g);
            #1;
        end
    endtask

    task automatic end_write();
        @(negedge clk_g);
        req = '0;
        check_eq("rsp.valid", 32'(rsp.valid), 32'd0);
    endtask

    task automatic end_read(output logic [31:0] rdata, output int acc_cycle);
        @(negedge clk_g);
        req       = '0;
        acc_cycle = cycle_cnt;
        check_eq("rsp.valid", 32'(rsp.valid), 32'd1);
        rdata = rsp.rdata;
    endtask

    task automatic bus_write(input logic [31:0] addr, input logic [31:0] wdata,
                             input logic [3:0] wstrb, output int stalls);
        start_access(addr, wdata, wstrb, 1'b0, stalls);
        end_write();
    endtask

    task automatic bus_read(input logic [31:0] addr, output logic [31:0] rdata,
                            output int acc_cycle);
        int stalls;
        start_access(addr, 32'd0, 4'h0, 1'b1, stalls);
        end_read(rdata, acc_cycle);
    endtask

    task automatic wait_status_bit(input int bit_pos);
        logic [31:0] st;
        int          c;
        st = '0;
        while (!st[bit_pos]) bus_read(STATUS_ADDR, st, c);
    endtask

    task automatic wait_tx_bytes(input int n);
        while (tx_seen.size() < n) @(negedge clk_g);
    endtask

    task automatic send_rx_byte(input logic [7:0] b);
        logic [9:0] frame;
        frame = {1'b1, b, 1'b0};
        for (int i = 0; i < 10; i++) begin
            rx = frame[i];
            repeat (CPB) @(negedge clk_g);
        end
    endtask

    task automatic report_test(input string name, input int errors_before);
        $display("%-22s finished, %0d failures", name, errors - errors_before);
    endtask

    // ======================================================================
    // Tests
    // ======================================================================

    task automatic test_data_memory();
        logic [31:0] addrs [4];
        logic [3:0]  strbs [4];
        logic [31:0] exp [4];
        logic [31:0] data;
        logic [31:0] rdata;
        int          stalls;
        int          c;
        int          e0;
        e0 = errors;
        addrs[0] = 32'h0000_0010;
        addrs[1] = 32'h0000_0104;
        addrs[2] = 32'h0000_7ffc;
        addrs[3] = 32'h0000_2468;
        strbs[0] = 4'hf;
        strbs[1] = 4'h3;
        strbs[2] = 4'hc;
        strbs[3] = 4'h5;
        for (int i = 0; i < 4; i++) begin
            data = rand_bits(32);
            start_access(addrs[i], data, strbs[i], 1'b0, stalls);
            check_eq("dmem.csb", 32'(dmem.csb), 32'd0);
            check_eq("dmem.web", 32'(dmem.web), 32'd0);
            check_eq("dmem.wmask", 32'(dmem.wmask), 32'(strbs[i]));
            check_eq("dmem.addr", 32'(dmem.addr), addrs[i] >> 2);
            check_eq("dmem.din", dmem.din, data);
            end_write();
            exp[i] = merge_bytes(fill_word(int'(addrs[i] >> 2)), data, strbs[i]);
        end
        // Read back on consecutive cycles
        for (int i = 0; i < 4; i++) begin
            start_access(addrs[i], 32'd0, 4'h0, 1'b1, stalls);
            check_eq("dmem.csb", 32'(dmem.csb), 32'd0);
            check_eq("dmem.web", 32'(dmem.web), 32'd1);
            end_read(rdata, c);
            check_eq("rsp.rdata", rdata, exp[i]);
        end
        report_test("data memory", e0);
    endtask

    task automatic test_instruction_memory();
        logic [31:0] addr;
        logic [31:0] data;
        logic [31:0] rdata;
        logic [31:0] exp;
        logic [3:0]  strb;
        int          waddr;
        int          stalls;
        int          c;
        int          e0;
        e0 = errors;
        for (int i = 0; i < 3; i++) begin
            addr  = soc_bus_pkg::IMEM_BASE + 32'(i * 12 + 4);
            waddr = int'((addr - soc_bus_pkg::IMEM_BASE) >> 2);
            data  = rand_bits(32);
            strb  = (i == 0) ? 4'hf : ((i == 1) ? 4'h6 : 4'h9);
            exp   = merge_bytes(~fill_word(waddr), data, strb);
            start_access(addr, data, strb, 1'b0, stalls);
            check_eq("imem.en", 32'(imem.en), 32'd1);
            check_eq("imem.addr", 32'(imem.addr), 32'(waddr));
            check_eq("imem.din", imem.din, data);
            check_eq("imem.wmask", 32'(imem.wmask), 32'(strb));
            end_write();
            check_eq("imem model word", imem_mem[waddr], exp);
        end
        bus_read(soc_bus_pkg::IMEM_BASE + 32'd4, rdata, c);
        check_eq("rsp.rdata imem read", rdata, 32'd0);
        bus_read(32'h3000_0000, rdata, c);
        check_eq("rsp.rdata unmapped read", rdata, 32'd0);
        report_test("instruction memory", e0);
    endtask

    task automatic test_uart_transmit();
        logic [7:0] sent [5];
        int         stalls;
        int         e0;
        e0 = errors;
        for (int i = 0; i < 5; i++) begin
            sent[i] = 8'(rand_bits(8));
            bus_write(TX_ADDR, {24'd0, sent[i]}, 4'h1, stalls);
        end
        wait_tx_bytes(5);
        for (int i = 0; i < 5; i++) check_eq("tx byte", 32'(tx_seen.pop_front()), 32'(sent[i]));
        report_test("uart transmit", e0);
    endtask

    task automatic test_back_pressure();
        logic [7:0]  sent [6];
        logic [31:0] st;
        int          stalls;
        int          c;
        int          e0;
        e0 = errors;
        for (int i = 0; i < 6; i++) sent[i] = 8'(rand_bits(8));
        // One byte leaves for the transmitter, four fill the FIFO
        for (int i = 0; i < 5; i++) bus_write(TX_ADDR, {24'd0, sent[i]}, 4'h1, stalls);
        bus_read(STATUS_ADDR, st, c);
        check_eq("status tx_full", 32'(st[uart_pkg::STAT_TX_FULL]), 32'd1);
        bus_write(TX_ADDR, {24'd0, sent[5]}, 4'h1, stalls);
        checks++;
        assert (stalls > 0) else begin
            errors++;
            $display("Ready never dropped for the write into the full tx FIFO at %0t", $time);
        end
        wait_tx_bytes(6);
        for (int i = 0; i < 6; i++) check_eq("tx byte", 32'(tx_seen.pop_front()), 32'(sent[i]));
        report_test("back-pressure", e0);
    endtask

    task automatic test_uart_receive();
        logic [7:0]  b0;
        logic [7:0]  b1;
        logic [7:0]  b2;
        logic [31:0] rdata;
        int          c;
        int          e0;
        e0 = errors;
        b0 = 8'(rand_bits(8));
        send_rx_byte(b0);
        wait_status_bit(uart_pkg::STAT_RX_VALID);
        bus_read(RX_ADDR, rdata, c);
        check_eq("rx data", rdata, {24'd0, b0});
        bus_read(STATUS_ADDR, rdata, c);
        check_eq("status after read", rdata, 32'd0);
        // Two bytes with no read between them
        b1 = 8'(rand_bits(8));
        b2 = 8'(rand_bits(8));
        send_rx_byte(b1);
        send_rx_byte(b2);
        wait_status_bit(uart_pkg::STAT_RX_OVERRUN);
        bus_read(STATUS_ADDR, rdata, c);
        check_eq("status overrun", rdata, 32'h6);
        bus_read(RX_ADDR, rdata, c);
        check_eq("rx data after overrun", rdata, {24'd0, b2});
        bus_read(STATUS_ADDR, rdata, c);
        check_eq("status after overrun read", rdata, 32'd0);
        report_test("uart receive", e0);
    endtask

    task automatic test_cycle_counter();
        logic [31:0] v1;
        logic [31:0] v2;
        int          c1;
        int          c2;
        int          gap;
        int          e0;
        e0 = errors;
        gap = 3 + int'(rand_bits(3));
        bus_read(CYCLES_ADDR, v1, c1);
        repeat (gap) @(negedge clk_g);
        bus_read(CYCLES_ADDR, v2, c2);
        check_eq("cycle difference", v2 - v1, 32'(c2 - c1));
        report_test("cycle counter", e0);
    endtask

    // ======================================================================
    // Main sequence
    // ======================================================================

    initial begin
        rst_g     = 1'b1;
        req       = '0;
        rx        = 1'b1;
        dmem_dout = '0;
        lfsr      = 32'h92e1;
        for (int i = 0; i < 2**soc_bus_pkg::DMEM_ADDR_BITS; i++) dmem_mem[i] = fill_word(i);
        for (int i = 0; i < 2**soc_bus_pkg::IMEM_ADDR_BITS; i++) imem_mem[i] = ~fill_word(i);
        repeat (10) @(negedge clk_g);
        rst_g = 1'b0;

        // State straight after reset
        #1;
        check_eq("tx", 32'(tx), 32'd1);
        check_eq("ready", 32'(ready), 32'd1);
        check_eq("rsp.valid", 32'(rsp.valid), 32'd0);
        check_eq("dmem.csb", 32'(dmem.csb), 32'd1);
        check_eq("dmem.web", 32'(dmem.web), 32'd1);
        check_eq("imem.en", 32'(imem.en), 32'd0);
        @(negedge clk_g);

        test_data_memory();
        test_instruction_memory();
        test_uart_transmit();
        test_back_pressure();
        test_uart_receive();
        test_cycle_counter();

        $display("Summary: %0d checks, %0d failures", checks, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

/* uart_pkg.sv */
// ==========================================================================
// UART definitions
// Frame constants, register offsets and transmitter/receiver states
// ==========================================================================

package uart_pkg;

    localparam int DATA_BITS_PER_FRAME = 8;

    typedef logic [DATA_BITS_PER_FRAME-1:0] uart_byte_t;

    // Byte offsets inside the 16-byte UART window
    localparam logic [3:0] REG_TX_DATA = 4'h0;
    localparam logic [3:0] REG_RX_DATA = 4'h4;
    localparam logic [3:0] REG_STATUS  = 4'h8;
    localparam logic [3:0] REG_CYCLES  = 4'hC;

    // Status bit positions
    localparam int STAT_TX_FULL = 0;
    localparam int STAT_RX_VALID = 1;
    localparam int STAT_RX_OVERRUN = 2;

    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_tx_state_e;

    typedef enum logic [1:0] {
        RX_IDLE,
        RX_START,
        RX_DATA,
        RX_STOP
    } uart_rx_state_e;

endpackage

/* uart_receiver.sv */
// ==========================================================================
// UART receiver
// Samples 8N1 frames at mid-bit into a one-byte holding register
// ==========================================================================
`timescale 1ns/1ps

module uart_receiver #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                 clk_g,
    input  logic                 rst_g,
    input  logic                 rx,
    input  logic                 rx_consume,
    output logic                 rx_valid,
    output uart_pkg::uart_byte_t rx_byte,
    output logic                 rx_overrun
);

    localparam int CNT_BITS = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    uart_pkg::uart_rx_state_e state;
    logic                     rx_meta;
    logic                     rx_sync;
    logic [CNT_BITS-1:0]      clk_cnt;
    logic [2:0]               bit_idx;
    uart_pkg::uart_byte_t     shift;
    logic                     half_end;
    logic                     bit_end;
    logic                     load;

    assign half_end = (clk_cnt == CNT_BITS'(CLKS_PER_BIT / 2 - 1));
    assign bit_end  = (clk_cnt == CNT_BITS'(CLKS_PER_BIT - 1));
    // Good stop bit sampled at mid-period
    assign load     = (state == uart_pkg::RX_STOP) && bit_end && rx_sync;

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            rx_meta    <= 1'b1;
            rx_sync    <= 1'b1;
            state      <= uart_pkg::RX_IDLE;
            clk_cnt    <= '0;
            bit_idx    <= '0;
            rx_valid   <= 1'b0;
            rx_overrun <= 1'b0;
        end else begin
            rx_meta <= rx;
            rx_sync <= rx_meta;
            clk_cnt <= clk_cnt + 1'b1;
            case (state)
                uart_pkg::RX_IDLE: begin
                    clk_cnt <= '0;
                    if (!rx_sync) state <= uart_pkg::RX_START;
                end
                uart_pkg::RX_START: begin
                    // Recheck the start bit at its middle
                    if (half_end) begin
                        clk_cnt <= '0;
                        bit_idx <= '0;
                        state   <= rx_sync ? uart_pkg::RX_IDLE : uart_pkg::RX_DATA;
                    end
                end
                uart_pkg::RX_DATA: begin
                    if (bit_end) begin
                        clk_cnt <= '0;
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= uart_pkg::RX_STOP;
                    end
                end
                default: begin
                    if (bit_end) state <= uart_pkg::RX_IDLE;
                end
            endcase

            if (load) begin
                rx_valid   <= 1'b1;
                rx_overrun <= rx_valid && !rx_consume;
            end else if (rx_consume) begin
                rx_valid   <= 1'b0;
                rx_overrun <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk_g) begin
        if (state == uart_pkg::RX_DATA && bit_end) begin
            shift <= {rx_sync, shift[7:1]};
        end
        if (load) begin
            rx_byte <= shift;
        end
    end

endmodule

/* uart_transmitter.sv */
// ==========================================================================
// UART transmitter
// Sends 8N1 frames LSB first, back to back while the FIFO has data
// ==========================================================================
`timescale 1ns/1ps

module uart_transmitter #(
    parameter int CLKS_PER_BIT = 868
) (
    input  logic                 clk_g,
    input  logic                 rst_g,
    input  logic                 tx_valid,
    input  uart_pkg::uart_byte_t tx_head,
    output logic                 tx_pop,
    output logic                 tx
);

    localparam int CNT_BITS = (CLKS_PER_BIT > 1) ? $clog2(CLKS_PER_BIT) : 1;

    uart_pkg::uart_tx_state_e state;
    logic [CNT_BITS-1:0]      clk_cnt;
    logic [2:0]               bit_idx;
    uart_pkg::uart_byte_t     shift;
    logic                     bit_end;

    assign bit_end = (clk_cnt == CNT_BITS'(CLKS_PER_BIT - 1));

    // Take a byte when idle, or at the end of a stop bit for no gap
    assign tx_pop = tx_valid && (state == uart_pkg::TX_IDLE ||
                                 (state == uart_pkg::TX_STOP && bit_end));

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            state   <= uart_pkg::TX_IDLE;
            clk_cnt <= '0;
            bit_idx <= '0;
        end else begin
            clk_cnt <= (bit_end || state == uart_pkg::TX_IDLE) ? '0 : clk_cnt + 1'b1;
            case (state)
                uart_pkg::TX_IDLE: begin
                    if (tx_pop) state <= uart_pkg::TX_START;
                end
                uart_pkg::TX_START: begin
                    if (bit_end) begin
                        state   <= uart_pkg::TX_DATA;
                        bit_idx <= '0;
                    end
                end
                uart_pkg::TX_DATA: begin
                    if (bit_end) begin
                        bit_idx <= bit_idx + 1'b1;
                        if (bit_idx == 3'd7) state <= uart_pkg::TX_STOP;
                    end
                end
                default: begin
                    if (bit_end) state <= tx_pop ? uart_pkg::TX_START : uart_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Shift register, LSB goes out first
    always_ff @(posedge clk_g) begin
        if (tx_pop) begin
            shift <= tx_head;
        end else if (state == uart_pkg::TX_DATA && bit_end) begin
            shift <= {1'b0, shift[7:1]};
        end
    end

    always_comb begin
        case (state)
            uart_pkg::TX_START: tx = 1'b0;
            uart_pkg::TX_DATA:  tx = shift[0];
            default:            tx = 1'b1;
        endcase
    end

endmodule

/* uart_tx_fifo.sv */
// ==========================================================================
// UART transmit FIFO
// Circular byte buffer between the bus write strobe and the transmitter
// ==========================================================================
`timescale 1ns/1ps

module uart_tx_fifo #(
    parameter int FIFO_DEPTH = 8
) (
    input  logic                 clk_g,
    input  logic                 rst_g,
    input  logic                 tx_push,
    input  uart_pkg::uart_byte_t tx_byte,
    input  logic                 tx_pop,
    output logic                 tx_full,
    output logic                 tx_valid,
    output uart_pkg::uart_byte_t tx_head
);

    localparam int PTR_BITS = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
    localparam int CNT_BITS = $clog2(FIFO_DEPTH + 1);

    uart_pkg::uart_byte_t mem [FIFO_DEPTH];
    logic [PTR_BITS-1:0]  wr_ptr;
    logic [PTR_BITS-1:0]  rd_ptr;
    logic [CNT_BITS-1:0]  count;

    always_ff @(posedge clk_g) begin
        if (rst_g) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (tx_push) begin
                wr_ptr <= (wr_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (tx_pop) begin
                rd_ptr <= (rd_ptr == PTR_BITS'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            count <= count + CNT_BITS'(tx_push) - CNT_BITS'(tx_pop);
        end
    end

    // Storage
    always_ff @(posedge clk_g) begin
        if (tx_push) begin
            mem[wr_ptr] <= tx_byte;
        end
    end

    assign tx_head  = mem[rd_ptr];
    assign tx_valid = (count != '0);
    assign tx_full  = (count == CNT_BITS'(FIFO_DEPTH));

endmodule
